// File: elink_config.svh
`ifndef ELINK_CONFIG_SVH
`define ELINK_CONFIG_SVH

// Packet width in bits, one emesh packet is 13 link bytes
`define PW 104

// Entries in each receive queue and initial link credits per queue
`define RX_DEPTH 4

// Responses the memory may issue before credits come back
`define RSP_CREDITS 2

// Words in the remote memory
`define MEM_WORDS 64

`endif

// File: emesh_pkg.sv
package emesh_pkg;

   // Control byte layout
   // Bit 1 marks a write and the other bits ride along untouched
   localparam int WRITE_BIT = 1;

   // Control byte width
   localparam int CTRL_W = 8;

   // Emesh packet with the most significant field first
   // The byte link sends ctrl first and srcaddr last
   typedef struct packed {
      logic [31:0]       srcaddr; // Return address for reads
      logic [31:0]       data;    // Write data or read result
      logic [31:0]       dstaddr; // Target byte address
      logic [CTRL_W-1:0] ctrl;    // Access type and mode bits
   } emesh_packet_t;

endpackage

// File: link_if.sv
`timescale 1ns/1ps

interface link_if;

   logic       frame;     // High for every byte of a packet
   logic [7:0] data;      // One packet byte per cycle
   logic       wr_credit; // One write queue entry freed
   logic       rd_credit; // One read queue entry freed

   // Transmit side drives bytes and takes credits back
   modport tx (
      output frame,
      output data,
      input  wr_credit,
      input  rd_credit
   );

   // Receive side takes bytes and hands credits back
   modport rx (
      input  frame,
      input  data,
      output wr_credit,
      output rd_credit
   );

endinterface

// File: link_tx.sv
`timescale 1ns/1ps
`include "elink_config.svh"

module link_tx import emesh_pkg::*; (
   input  logic          clkin,
   input  logic          reset,
   input  logic          host_access,  // Host offers a packet
   input  emesh_packet_t host_packet,
   output logic          host_wr_wait, // Hold off writes
   output logic          host_rd_wait, // Hold off reads
   link_if.tx            link
);

   localparam int NBYTES = `PW / 8;                 // Bytes per frame
   localparam int CNT_W  = $clog2(NBYTES);
   localparam int CRD_W  = $clog2(`RX_DEPTH + 1);   // Room for a full count

   logic [`PW-1:0]   shift_q;   // Packet on its way out
   logic [CNT_W-1:0] byte_cnt;  // Byte now on the link
   logic             busy;      // Frame in progress
   logic [CRD_W-1:0] wr_cred;   // Free entries in far write queue
   logic [CRD_W-1:0] rd_cred;   // Free entries in far read queue
   logic             last_byte; // Final byte of the frame
   logic             hold;      // Shifter cannot take a packet
   logic             is_write;
   logic             wr_take;   // Write accepted this cycle
   logic             rd_take;   // Read accepted this cycle

   assign last_byte = busy && (byte_cnt == CNT_W'(NBYTES - 1));
   assign hold      = busy && !last_byte; // Free again in the last byte cycle
   assign is_write  = host_packet.ctrl[WRITE_BIT];

   assign host_wr_wait = (wr_cred == '0) || hold;
   assign host_rd_wait = (rd_cred == '0) || hold;

   assign wr_take = host_access && is_write && !host_wr_wait;
   assign rd_take = host_access && !is_write && !host_rd_wait;

   assign link.frame = busy;
   assign link.data  = shift_q[7:0]; // Least significant byte first

   // Frame control, a new take restarts the count
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         busy     <= 1'b0;
         byte_cnt <= '0;
      end else if (wr_take || rd_take) begin
         busy     <= 1'b1;            // Frame rises next cycle
         byte_cnt <= '0;
      end else if (busy) begin
         busy     <= !last_byte;
         byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
      end
   end

   // Payload shifter
   always_ff @(posedge clkin) begin
      if (wr_take || rd_take)
         shift_q <= host_packet;
      else if (busy)
         shift_q <= {8'h00, shift_q[`PW-1:8]}; // Next byte down
   end

   // Credits spent on accept, returned by the receiver on pop
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         wr_cred <= CRD_W'(`RX_DEPTH); // Queues start empty
         rd_cred <= CRD_W'(`RX_DEPTH);
      end else begin
         wr_cred <= wr_cred - CRD_W'(wr_take) + CRD_W'(link.wr_credit);
         rd_cred <= rd_cred - CRD_W'(rd_take) + CRD_W'(link.rd_credit);
      end
   end

   // An underflow wraps above the depth, as would a surplus return from link_rx
   a_cred_range: assert property (@(posedge clkin) disable iff (reset)
      (wr_cred <= CRD_W'(`RX_DEPTH)) && (rd_cred <= CRD_W'(`RX_DEPTH)))
      else $error("link_tx credit out of range wr=%0d rd=%0d", wr_cred, rd_cred);

endmodule

// File: link_rx.sv
`timescale 1ns/1ps
`include "elink_config.svh"

module link_rx import emesh_pkg::*; (
   input  logic          clkin,
   input  logic          reset,
   link_if.rx            link,
   output logic          wr_valid, // Write queue not empty
   output emesh_packet_t wr_head,
   input  logic          wr_pop,   // Arbiter takes the write head
   output logic          rd_valid, // Read queue not empty
   output emesh_packet_t rd_head,
   input  logic          rd_pop    // Arbiter takes the read head
);

   localparam int NBYTES  = `PW / 8;
   localparam int CNT_W   = $clog2(NBYTES);
   localparam int PTR_W   = $clog2(`RX_DEPTH);
   localparam int FILL_W  = $clog2(`RX_DEPTH + 1);

   logic [`PW-9:0]      shift_q;   // First twelve bytes of the frame
   logic [CNT_W-1:0]    byte_cnt;  // Bytes seen in this frame
   logic                frame_end; // Last byte is on the link
   emesh_packet_t       rx_packet; // Assembled packet at frame end
   logic [1:0]          push;      // Queue 0 holds writes, queue 1 reads
   logic [1:0]          pop;
   logic [1:0]          valid;
   emesh_packet_t [1:0] head;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(`RX_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign frame_end = link.frame && (byte_cnt == CNT_W'(NBYTES - 1));
   assign rx_packet = {link.data, shift_q}; // Last byte lands on top

   // Steer by the write flag
   assign push[0] = frame_end && rx_packet.ctrl[WRITE_BIT];
   assign push[1] = frame_end && !rx_packet.ctrl[WRITE_BIT];
   assign pop     = {rd_pop, wr_pop};

   // Byte count restarts at every packet boundary, frames may abut
   always_ff @(posedge clkin or posedge reset) begin
      if (reset)
         byte_cnt <= '0;
      else if (link.frame)
         byte_cnt <= frame_end ? '0 : byte_cnt + 1'b1;
   end

   always_ff @(posedge clkin) begin
      if (link.frame)
         shift_q <= {link.data, shift_q[`PW-9:8]}; // Earlier bytes move down
   end

   for (genvar q = 0; q < 2; q++) begin : g_queue
      emesh_packet_t     mem [`RX_DEPTH]; // Circular storage
      logic [PTR_W-1:0]  wr_ptr;
      logic [PTR_W-1:0]  rd_ptr;
      logic [FILL_W-1:0] fill;            // Entries held

      always_ff @(posedge clkin) begin
         if (push[q])
            mem[wr_ptr] <= rx_packet;
      end

      always_ff @(posedge clkin or posedge reset) begin
         if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
         end else begin
            if (push[q])
               wr_ptr <= next_ptr(wr_ptr);
            if (pop[q])
               rd_ptr <= next_ptr(rd_ptr); // Head leaves in the pop cycle
            fill <= fill + FILL_W'(push[q]) - FILL_W'(pop[q]);
         end
      end

      assign valid[q] = (fill != '0);
      assign head[q]  = mem[rd_ptr];

      // Holds only if link_tx never sends past its credits
      a_no_overflow: assert property (@(posedge clkin) disable iff (reset)
         push[q] |-> (fill < FILL_W'(`RX_DEPTH)))
         else $error("link_rx push into full queue %0d", q);
   end

   assign wr_valid = valid[0];
   assign wr_head  = head[0];
   assign rd_valid = valid[1];
   assign rd_head  = head[1];

   // One credit back per popped entry, same cycle
   assign link.wr_credit = wr_pop;
   assign link.rd_credit = rd_pop;

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps
`include "elink_config.svh"

module mem_arbiter import emesh_pkg::*; (
   input  logic          clkin,
   input  logic          reset,
   input  logic          wr_valid,
   input  emesh_packet_t wr_head,
   output logic          wr_pop,     // Write head granted
   input  logic          rd_valid,
   input  emesh_packet_t rd_head,
   output logic          rd_pop,     // Read head granted
   output logic          mem_access, // Request to memory this cycle
   output emesh_packet_t mem_packet,
   input  logic          rsp_ready   // Memory may answer a read
);

   logic [31:0] wr_grants; // Writes granted since reset
   logic [31:0] rd_grants; // Reads granted since reset

   // Writes always win and reads wait for a response credit
   assign wr_pop = wr_valid;
   assign rd_pop = !wr_valid && rd_valid && rsp_ready;

   assign mem_access = wr_pop || rd_pop;
   assign mem_packet = wr_valid ? wr_head : rd_head;

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         wr_grants <= '0;
         rd_grants <= '0;
      end else begin
         wr_grants <= wr_grants + 32'(wr_pop);
         rd_grants <= rd_grants + 32'(rd_pop);
      end
   end

   // Each queue must hold only its own kind of packet
   a_wr_pop_kind: assert property (@(posedge clkin) disable iff (reset)
      wr_pop |-> wr_head.ctrl[WRITE_BIT])
      else $error("read packet granted from write queue after %0d writes", wr_grants);

   a_rd_pop_kind: assert property (@(posedge clkin) disable iff (reset)
      rd_pop |-> !rd_head.ctrl[WRITE_BIT])
      else $error("write packet granted from read queue after %0d reads", rd_grants);

endmodule

// File: emem.sv
`timescale 1ns/1ps
`include "elink_config.svh"

module emem import emesh_pkg::*; (
   input  logic          clkin,
   input  logic          reset,
   input  logic          mem_access, // Granted request
   input  emesh_packet_t mem_packet,
   output logic          rsp_ready,  // A response credit is free
   output logic          rsp_access, // Response valid, one cycle
   output emesh_packet_t rsp_packet,
   input  logic          rsp_credit  // One response credit returned
);

   localparam int IDX_W = $clog2(`MEM_WORDS);
   localparam int CRD_W = $clog2(`RSP_CREDITS + 1);

   logic [31:0]      mem [`MEM_WORDS]; // Word storage
   logic [IDX_W-1:0] idx;              // Word index from dstaddr
   logic             wr_req;
   logic             rd_req;
   logic [CRD_W-1:0] cred;             // Response credits left

   assign idx    = mem_packet.dstaddr[IDX_W+1:2]; // Skip byte offset
   assign wr_req = mem_access && mem_packet.ctrl[WRITE_BIT];
   assign rd_req = mem_access && !mem_packet.ctrl[WRITE_BIT];

   assign rsp_ready = (cred != '0);

   always_ff @(posedge clkin) begin
      if (wr_req)
         mem[idx] <= mem_packet.data;
   end

   // Response swaps the addresses and comes back as a write
   always_ff @(posedge clkin) begin
      if (rd_req) begin
         rsp_packet.srcaddr <= mem_packet.dstaddr;
         rsp_packet.data    <= mem[idx];
         rsp_packet.dstaddr <= mem_packet.srcaddr; // Back to the requester
         rsp_packet.ctrl    <= mem_packet.ctrl | CTRL_W'(1 << WRITE_BIT);
      end
   end

   always_ff @(posedge clkin or posedge reset) begin
      if (reset)
         rsp_access <= 1'b0;
      else
         rsp_access <= rd_req; // One cycle after the grant
   end

   // Spent at grant, returned from outside
   always_ff @(posedge clkin or posedge reset) begin
      if (reset)
         cred <= CRD_W'(`RSP_CREDITS);
      else
         cred <= cred - CRD_W'(rd_req) + CRD_W'(rsp_credit);
   end

   // Relies on the arbiter holding reads while rsp_ready is low
   a_rsp_credit: assert property (@(posedge clkin) disable iff (reset)
      rsp_access |-> ($past(cred) != '0))
      else $error("emem response issued with no credit");

endmodule

// File: elink_top.sv
`timescale 1ns/1ps
`include "elink_config.svh"

module elink_top import emesh_pkg::*; (
   input  logic           clkin,
   input  logic           reset,
   input  logic           host_access,  // Host packet valid
   input  logic [`PW-1:0] host_packet,
   output logic           host_wr_wait, // Writes held off
   output logic           host_rd_wait, // Reads held off
   output logic           rsp_access,   // Read response valid
   output logic [`PW-1:0] rsp_packet,
   input  logic           rsp_credit    // Returns one response credit
);

   link_if link ();              // Byte link with credit returns

   logic          wr_valid;
   logic          wr_pop;
   logic          rd_valid;
   logic          rd_pop;
   logic          mem_access;
   logic          rsp_ready;
   emesh_packet_t wr_head;       // Head of write queue
   emesh_packet_t rd_head;       // Head of read queue
   emesh_packet_t mem_packet;    // Granted request

   link_tx link_tx_inst (
      .clkin        (clkin),
      .reset        (reset),
      .host_access  (host_access),
      .host_packet  (emesh_packet_t'(host_packet)),
      .host_wr_wait (host_wr_wait),
      .host_rd_wait (host_rd_wait),
      .link         (link.tx)
   );

   link_rx link_rx_inst (
      .clkin    (clkin),
      .reset    (reset),
      .link     (link.rx),
      .wr_valid (wr_valid),
      .wr_head  (wr_head),
      .wr_pop   (wr_pop),
      .rd_valid (rd_valid),
      .rd_head  (rd_head),
      .rd_pop   (rd_pop)
   );

   mem_arbiter mem_arbiter_inst (
      .clkin      (clkin),
      .reset      (reset),
      .wr_valid   (wr_valid),
      .wr_head    (wr_head),
      .wr_pop     (wr_pop),
      .rd_valid   (rd_valid),
      .rd_head    (rd_head),
      .rd_pop     (rd_pop),
      .mem_access (mem_access),
      .mem_packet (mem_packet),
      .rsp_ready  (rsp_ready)
   );

   emem emem_inst (
      .clkin      (clkin),
      .reset      (reset),
      .mem_access (mem_access),
      .mem_packet (mem_packet),
      .rsp_ready  (rsp_ready),
      .rsp_access (rsp_access),
      .rsp_packet (rsp_packet),
      .rsp_credit (rsp_credit)
   );

endmodule

// File: tb_elink.sv
`timescale 1ns/1ps
`include "elink_config.svh"

module tb_elink;

   localparam logic [7:0] CTRL_WR    = 8'h03; // Write flag plus a mode bit
   localparam logic [7:0] CTRL_RD    = 8'h04; // Read, mode bit must ride along
   localparam logic [7:0] WRITE_MASK = 8'h02; // Bit 1 of ctrl marks a write
   localparam int ACCEPT_LIMIT = 200;          // Cycles a host packet may stall
   localparam int EVENT_LIMIT  = 400;          // Cycles for any other wait
   localparam int HELD_READS   = 6;            // Reads issued while credits held

   logic           clkin = 1'b0;
   logic           reset = 1'b1;
   logic           host_access = 1'b0;
   logic [`PW-1:0] host_packet = '0;
   logic           host_wr_wait;
   logic           host_rd_wait;
   logic           rsp_access;
   logic [`PW-1:0] rsp_packet;
   logic           rsp_credit = 1'b0;

   string          tbl_name [$];          // Stimulus table, one entry per packet
   bit             tbl_write [$];
   logic [31:0]    tbl_addr [$];
   logic [31:0]    tbl_src [$];
   logic [31:0]    tbl_data [$];

   logic [31:0]    shadow [`MEM_WORDS];   // Reference copy of remote memory
   string          exp_name [$];          // Outstanding reads in issue order
   logic [`PW-1:0] exp_pkt [$];
   logic [31:0]    lfsr = 32'hcb9b;
   int             errors = 0;
   int             rsp_seen = 0;          // Responses observed
   int             owed = 0;              // Credits due back to emem
   int             returned = 0;          // Credits already pulsed
   bit             hold_credits = 1'b0;   // Withhold rsp_credit
   int             rsp_base;
   int             n_main;
   int             n_hold_rd;
   int             n_hold_wr;

   elink_top elink_top_inst (
      .clkin        (clkin),
      .reset        (reset),
      .host_access  (host_access),
      .host_packet  (host_packet),
      .host_wr_wait (host_wr_wait),
      .host_rd_wait (host_rd_wait),
      .rsp_access   (rsp_access),
      .rsp_packet   (rsp_packet),
      .rsp_credit   (rsp_credit)
   );

   always #5 clkin = ~clkin; // 10 ns period

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_word(output logic [31:0] w);
      for (int b = 0; b < 32; b++) begin
         lfsr = lfsr_next(lfsr);
         w = {w[30:0], lfsr[0]}; // One step per bit taken
      end
   endtask

   function automatic int word_index(input logic [31:0] addr);
      return int'((addr >> 2) % `MEM_WORDS); // Byte offset dropped
   endfunction

   task automatic add_entry(input string name, input bit is_write,
                            input logic [31:0] addr, input logic [31:0] src);
      logic [31:0] word;
      draw_word(word);
      tbl_name.push_back(name);
      tbl_write.push_back(is_write);
      tbl_addr.push_back(addr);
      tbl_src.push_back(src);
      tbl_data.push_back(word);
   endtask

   task automatic check_value(input string name, input logic [`PW-1:0] expected,
                              input logic [`PW-1:0] actual);
      if (actual !== expected) begin
         errors = errors + 1;
         $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   task automatic check_response(input string name, input logic [`PW-1:0] expected,
                                 input logic [`PW-1:0] actual);
      check_value({name, " srcaddr"}, `PW'(expected[103:72]), `PW'(actual[103:72]));
      check_value({name, " data"}, `PW'(expected[71:40]), `PW'(actual[71:40]));
      check_value({name, " dstaddr"}, `PW'(expected[39:8]), `PW'(actual[39:8]));
      check_value({name, " ctrl"}, `PW'(expected[7:0]), `PW'(actual[7:0]));
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timeout: %s", what);
      $display("Errors: %0d check failures and one timeout", errors);
      $display("Result: FAILED");
      $fatal(1, "run stopped after a wait ran out of time");
   endtask

   // Entered at 1 ns past a rising edge, returns at the same phase
   task automatic send_entry(input int i);
      logic [7:0] ctrl;
      int         cycles;
      bit         taken;
      ctrl        = tbl_write[i] ? CTRL_WR : CTRL_RD;
      host_packet = {tbl_src[i], tbl_data[i], tbl_addr[i], ctrl};
      host_access = 1'b1;
      cycles      = 0;
      taken       = 1'b0;
      while (!taken) begin
         @(negedge clkin);
         taken = tbl_write[i] ? !host_wr_wait : !host_rd_wait; // Taken at next edge
         @(posedge clkin);
         #1;
         cycles++;
         if (!taken && cycles > ACCEPT_LIMIT)
            stop_on_timeout({"host port never accepted ", tbl_name[i]});
      end
      host_access = 1'b0;
      if (tbl_write[i]) begin
         shadow[word_index(tbl_addr[i])] = tbl_data[i];
      end else begin
         // Response swaps addresses and is marked as a write
         exp_name.push_back(tbl_name[i]);
         exp_pkt.push_back({tbl_addr[i], shadow[word_index(tbl_addr[i])],
                            tbl_src[i], ctrl | WRITE_MASK});
      end
   endtask

   task automatic apply_range(input int first, input int last);
      for (int i = first; i <= last; i++)
         send_entry(i);
   endtask

   task automatic wait_rd_blocked();
      int cycles;
      bit blocked;
      cycles  = 0;
      blocked = 1'b0;
      while (!blocked) begin
         @(negedge clkin);
         blocked = host_rd_wait && !host_wr_wait; // Link idle, read credits gone
         @(posedge clkin);
         #1;
         cycles++;
         if (!blocked && cycles > EVENT_LIMIT)
            stop_on_timeout("host_rd_wait never rose while response credits were held");
      end
   endtask

   task automatic wait_drain(input string what);
      int cycles;
      bit idle;
      cycles = 0;
      idle   = 1'b0;
      while (!idle) begin
         @(negedge clkin);
         idle = (exp_pkt.size() == 0) && (returned == owed);
         @(posedge clkin);
         #1;
         cycles++;
         if (!idle && cycles > EVENT_LIMIT)
            stop_on_timeout({"responses still missing while waiting for ", what});
      end
   endtask

   // Scoreboard, responses must match reads in issue order
   always @(negedge clkin) begin
      if (!reset && rsp_access) begin
         rsp_seen = rsp_seen + 1;
         owed     = owed + 1;
         if (exp_pkt.size() == 0) begin
            errors = errors + 1;
            $display("A response arrived with no read outstanding, packet %0h", rsp_packet);
         end else begin
            check_response(exp_name.pop_front(), exp_pkt.pop_front(), rsp_packet);
         end
      end
   end

   // One credit pulse per response unless held
   always @(posedge clkin) begin
      #1;
      if (!hold_credits && (returned < owed)) begin
         rsp_credit = 1'b1;
         returned   = returned + 1;
      end else begin
         rsp_credit = 1'b0;
      end
   end

   initial begin
      add_entry("write a0", 1'b1, 32'h0000_0010, 32'h0000_0000);
      add_entry("read a0", 1'b0, 32'h0000_0010, 32'h8000_0100);
      add_entry("write b0", 1'b1, 32'h0000_0020, 32'h0000_0000);
      add_entry("write b1", 1'b1, 32'h0000_0024, 32'h0000_0000);
      add_entry("read b0", 1'b0, 32'h0000_0020, 32'h8000_0200);
      add_entry("write c0", 1'b1, 32'h0000_003c, 32'h0000_0000);
      add_entry("read b1", 1'b0, 32'h0000_0024, 32'h8000_0204);
      add_entry("overwrite a0", 1'b1, 32'h0000_0010, 32'h0000_0000);
      add_entry("read a0 again", 1'b0, 32'h0000_0010, 32'h8000_0108);
      add_entry("read c0", 1'b0, 32'h0000_003c, 32'h8000_023c);
      add_entry("write top word", 1'b1, 32'h0000_00fc, 32'h0000_0000);
      add_entry("read top word", 1'b0, 32'h0000_00fc, 32'h8000_02fc);
      add_entry("write word zero", 1'b1, 32'h0000_0000, 32'h0000_0000);
      add_entry("read word zero", 1'b0, 32'h0000_0000, 32'h8000_0300);
      n_main = tbl_name.size();
      add_entry("held read 0", 1'b0, 32'h0000_0020, 32'h8000_1000); // Uses a credit
      add_entry("held read 1", 1'b0, 32'h0000_0024, 32'h8000_1004); // Uses the last one
      add_entry("held read 2", 1'b0, 32'h0000_0010, 32'h8000_1008);
      add_entry("held read 3", 1'b0, 32'h0000_003c, 32'h8000_100c);
      add_entry("held read 4", 1'b0, 32'h0000_00fc, 32'h8000_1010);
      add_entry("held read 5", 1'b0, 32'h0000_0000, 32'h8000_1014); // Read queue full
      n_hold_rd = tbl_name.size();
      add_entry("write during hold 0", 1'b1, 32'h0000_0040, 32'h0000_0000);
      add_entry("write during hold 1", 1'b1, 32'h0000_0044, 32'h0000_0000);
      n_hold_wr = tbl_name.size();
      add_entry("read hold write 0", 1'b0, 32'h0000_0040, 32'h8000_2040);
      add_entry("read hold write 1", 1'b0, 32'h0000_0044, 32'h8000_2044);

      repeat (16) @(posedge clkin);
      #1;
      reset = 1'b0;
      @(negedge clkin);
      check_value("reset rsp_access", '0, `PW'(rsp_access));
      check_value("reset host_wr_wait", '0, `PW'(host_wr_wait));
      check_value("reset host_rd_wait", '0, `PW'(host_rd_wait));
      @(posedge clkin);
      #1;

      apply_range(0, n_main - 1);
      wait_drain("the main table");

      // Response credits withheld, reads back up into the link
      hold_credits = 1'b1;
      rsp_base     = rsp_seen;
      apply_range(n_main, n_hold_rd - 1);
      wait_rd_blocked();
      apply_range(n_hold_rd, n_hold_wr - 1); // Writes still get through
      if (rsp_seen - rsp_base > `RSP_CREDITS) begin
         errors = errors + 1;
         $display("More responses than credits while credits were held: %0d",
                  rsp_seen - rsp_base);
      end
      check_value("reads pending during hold", `PW'(HELD_READS - `RSP_CREDITS),
                  `PW'(exp_pkt.size()));
      hold_credits = 1'b0;

      apply_range(n_hold_wr, tbl_name.size() - 1);
      wait_drain("the reads held back by credits");

      $display("Errors: %0d check failures", errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: compile.f
+incdir+.
emesh_pkg.sv
link_if.sv
link_tx.sv
link_rx.sv
mem_arbiter.sv
emem.sv
elink_top.sv
tb_elink.sv

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_elink \
   -f compile.f --Mdir obj_dir -o tb_elink_sim > build.log 2>&1 &&
   ./obj_dir/tb_elink_sim > sim.log 2>&1
grep -qx "Result: PASSED" sim.log && echo "elink simulation passed" ||
   { cat build.log sim.log 2>/dev/null; echo "elink simulation failed"; exit 1; }
